// File: Makefile
# Verilator build of tb_periph_core; the run fails when the log shows the fail message
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module tb_periph_core -f filelist.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_periph_core \
		-f filelist.f -o sim_periph
	./obj_dir/sim_periph | tee $(LOG)
	@if grep -q "sim failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "sim passed" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)

// File: design/ahb_sync_sram.sv
// Zero-wait AHB-Lite SRAM, byte/halfword/word writes little-endian, no error responses
module ahb_sync_sram (
	input  logic                  clk,
	input  logic                  reset,
	input  periph_pkg::ahb_req_t  ahbls_req,
	input  periph_pkg::data_t     ahbls_hwdata,
	output periph_pkg::ahb_resp_t ahbls_resp
);

periph_pkg::data_t mem [periph_pkg::SRAM_DEPTH];

logic                          trans_valid;
logic                          dph_active;
logic                          dph_write;
periph_pkg::sram_idx_t         dph_idx;
logic [1:0]                    dph_byte;
periph_pkg::hsize_t            dph_size;
logic [periph_pkg::N_LANES-1:0] lanes;

assign trans_valid = ahbls_req.htrans == periph_pkg::HTRANS_NONSEQ ||
	ahbls_req.htrans == periph_pkg::HTRANS_SEQ;

// ====================
// Address phase capture
// ====================
always_ff @(posedge clk) begin
	if (reset) begin
		dph_active <= 1'b0;
		dph_write  <= 1'b0;
	end else if (ahbls_req.hready) begin
		dph_active <= trans_valid;
		dph_write  <= ahbls_req.hwrite;
	end
end

always_ff @(posedge clk) begin
	if (ahbls_req.hready && trans_valid) begin
		dph_idx  <= ahbls_req.haddr[periph_pkg::W_SRAM_IDX+1:2];
		dph_byte <= ahbls_req.haddr[1:0];
		dph_size <= ahbls_req.hsize;
	end
end

// Lane 0 is the lowest byte address
always_comb begin
	case (dph_size)
		periph_pkg::HSIZE_BYTE: lanes = 4'b0001 << dph_byte;
		periph_pkg::HSIZE_HALF: lanes = dph_byte[1] ? 4'b1100 : 4'b0011;
		default:                lanes = 4'b1111;
	endcase
end

// ====================
// Data phase
// ====================
always_ff @(posedge clk) begin
	if (dph_active && dph_write) begin
		for (int i = 0; i < periph_pkg::N_LANES; i++) begin
			if (lanes[i])
				mem[dph_idx][8*i +: 8] <= ahbls_hwdata[8*i +: 8];
		end
	end
end

assign ahbls_resp.hready_resp = 1'b1;
assign ahbls_resp.hresp       = 1'b0;
assign ahbls_resp.hrdata      = mem[dph_idx];

a_size_max: assert property (@(posedge clk) disable iff (reset)
	ahbls_req.hready && trans_valid |-> ahbls_req.hsize <= periph_pkg::HSIZE_WORD)
	else $error("SRAM transfer wider than a word");

endmodule

// File: design/ahbl_decoder.sv
// Single-master AHB-Lite decoder; src_req.hready must carry the returned hready_resp
module ahbl_decoder (
	input  logic                  clk,
	input  logic                  reset,
	input  periph_pkg::ahb_req_t  src_req,
	output periph_pkg::ahb_resp_t src_resp,
	output periph_pkg::ahb_req_t  sram_req,
	input  periph_pkg::ahb_resp_t sram_resp,
	output periph_pkg::ahb_req_t  bridge_req,
	input  periph_pkg::ahb_resp_t bridge_resp
);

// Slave that owns the current data phase
typedef enum logic [1:0] {
	OWN_NONE,
	OWN_SRAM,
	OWN_BRIDGE,
	OWN_ERR
} owner_t;

owner_t owner;
logic   err_phase2;
logic   trans_valid;
logic   sel_sram;
logic   sel_bridge;

assign trans_valid = src_req.htrans == periph_pkg::HTRANS_NONSEQ ||
	src_req.htrans == periph_pkg::HTRANS_SEQ;
assign sel_sram   = (src_req.haddr & periph_pkg::REGION_MASK) == periph_pkg::SRAM_BASE;
assign sel_bridge = (src_req.haddr & periph_pkg::REGION_MASK) == periph_pkg::APB_BASE;

// Unselected slaves only ever see IDLE
always_comb begin
	sram_req   = src_req;
	bridge_req = src_req;
	if (!sel_sram)
		sram_req.htrans = periph_pkg::HTRANS_IDLE;
	if (!sel_bridge)
		bridge_req.htrans = periph_pkg::HTRANS_IDLE;
end

always_ff @(posedge clk) begin
	if (reset) begin
		owner      <= OWN_NONE;
		err_phase2 <= 1'b0;
	end else if (src_req.hready) begin
		err_phase2 <= 1'b0;
		if (!trans_valid)
			owner <= OWN_NONE;
		else if (sel_sram)
			owner <= OWN_SRAM;
		else if (sel_bridge)
			owner <= OWN_BRIDGE;
		else
			owner <= OWN_ERR;
	end else if (owner == OWN_ERR) begin
		// First error cycle done, release hready next
		err_phase2 <= 1'b1;
	end
end

always_comb begin
	case (owner)
		OWN_SRAM:   src_resp = sram_resp;
		OWN_BRIDGE: src_resp = bridge_resp;
		OWN_ERR:    src_resp = '{hready_resp: err_phase2, hresp: 1'b1, hrdata: '0};
		default:    src_resp = '{hready_resp: 1'b1, hresp: 1'b0, hrdata: '0};
	endcase
end

// A stalled data phase keeps its slave until the master sees ready
a_owner_hold: assert property (@(posedge clk) disable iff (reset)
	!src_resp.hready_resp |=> $stable(owner))
	else $error("data-phase owner changed during a wait state");

endmodule

// File: design/ahbl_to_apb.sv
// AHB-Lite to APB bridge, word transfers only; paddr is the low 16 bits of haddr
module ahbl_to_apb (
	input  logic                  clk,
	input  logic                  reset,
	input  periph_pkg::ahb_req_t  ahbls_req,
	input  periph_pkg::data_t     ahbls_hwdata,
	output periph_pkg::ahb_resp_t ahbls_resp,
	output periph_pkg::apb_req_t  apbm_req,
	input  periph_pkg::apb_resp_t apbm_resp
);

periph_pkg::bridge_state_t state;
periph_pkg::paddr_t        paddr_q;
logic                      pwrite_q;
periph_pkg::data_t         rdata_q;
logic                      trans_valid;
logic                      can_accept;
logic                      take;

assign trans_valid = ahbls_req.htrans == periph_pkg::HTRANS_NONSEQ ||
	ahbls_req.htrans == periph_pkg::HTRANS_SEQ;
// IDLE and ERR2 are the cycles where hready_resp is high
assign can_accept = state == periph_pkg::BR_IDLE || state == periph_pkg::BR_ERR2;
assign take       = can_accept && ahbls_req.hready && trans_valid;

// ====================
// State machine
// ====================
always_ff @(posedge clk) begin
	if (reset) begin
		state <= periph_pkg::BR_IDLE;
	end else begin
		case (state)
			periph_pkg::BR_IDLE, periph_pkg::BR_ERR2: begin
				if (take)
					state <= periph_pkg::BR_SETUP;
				else
					state <= periph_pkg::BR_IDLE;
			end
			periph_pkg::BR_SETUP: state <= periph_pkg::BR_ACCESS;
			periph_pkg::BR_ACCESS: begin
				if (apbm_resp.pready && apbm_resp.pslverr)
					state <= periph_pkg::BR_ERR2;
				else if (apbm_resp.pready)
					state <= periph_pkg::BR_IDLE;
			end
			default: state <= periph_pkg::BR_IDLE;
		endcase
	end
end

always_ff @(posedge clk) begin
	if (take) begin
		paddr_q  <= ahbls_req.haddr[periph_pkg::W_PADDR-1:0];
		pwrite_q <= ahbls_req.hwrite;
	end
	if (state == periph_pkg::BR_ACCESS && apbm_resp.pready)
		rdata_q <= apbm_resp.prdata;
end

// ====================
// Bus outputs
// ====================
always_comb begin
	apbm_req.paddr   = paddr_q;
	apbm_req.psel    = state == periph_pkg::BR_SETUP || state == periph_pkg::BR_ACCESS;
	apbm_req.penable = state == periph_pkg::BR_ACCESS;
	apbm_req.pwrite  = pwrite_q;
	// hwdata is held by the master for the whole data phase
	apbm_req.pwdata  = ahbls_hwdata;

	ahbls_resp.hready_resp = can_accept;
	// First error cycle is the failing access, second is ERR2
	ahbls_resp.hresp = state == periph_pkg::BR_ERR2 ||
		(state == periph_pkg::BR_ACCESS && apbm_resp.pready && apbm_resp.pslverr);
	ahbls_resp.hrdata = rdata_q;
end

// Access cycles keep the select and the write data of their setup cycle
a_access_hold: assert property (@(posedge clk) disable iff (reset)
	apbm_req.penable |-> apbm_req.psel && $stable(apbm_req.pwdata))
	else $error("APB access without psel or with changing write data");

a_word_only: assert property (@(posedge clk) disable iff (reset)
	take |-> ahbls_req.hsize == periph_pkg::HSIZE_WORD)
	else $error("non-word transfer sent to the APB bridge");

endmodule

// File: design/apb_splitter.sv
// APB splitter for PWM at 0x0000 and GPIO at 0x1000; other blocks answer with pslverr
module apb_splitter (
	input  periph_pkg::apb_req_t  apbs_req,
	output periph_pkg::apb_resp_t apbs_resp,
	output periph_pkg::apb_req_t  pwm_req,
	input  periph_pkg::apb_resp_t pwm_resp,
	output periph_pkg::apb_req_t  gpio_req,
	input  periph_pkg::apb_resp_t gpio_resp
);

logic hit_pwm;
logic hit_gpio;

assign hit_pwm  = (apbs_req.paddr & periph_pkg::PERIPH_MASK) == periph_pkg::PWM_BASE;
assign hit_gpio = (apbs_req.paddr & periph_pkg::PERIPH_MASK) == periph_pkg::GPIO_BASE;

always_comb begin
	pwm_req       = apbs_req;
	gpio_req      = apbs_req;
	pwm_req.psel  = apbs_req.psel && hit_pwm;
	gpio_req.psel = apbs_req.psel && hit_gpio;

	if (hit_pwm)
		apbs_resp = pwm_resp;
	else if (hit_gpio)
		apbs_resp = gpio_resp;
	else
		apbs_resp = '{pready: 1'b1, prdata: '0, pslverr: 1'b1};
end

endmodule

// File: design/gpio.sv
// APB GPIO with separate in/out/oe vectors; GPIO_IN lags the pads by two clocks
module gpio (
	input  logic                  clk,
	input  logic                  reset,
	input  periph_pkg::apb_req_t  apbs_req,
	output periph_pkg::apb_resp_t apbs_resp,
	input  logic                  pwm,
	input  periph_pkg::gpio_t     gpio_in,
	output periph_pkg::gpio_t     gpio_out,
	output periph_pkg::gpio_t     gpio_oe
);

periph_pkg::gpio_t    out_r;
periph_pkg::gpio_t    oe_r;
logic                 fsel;
periph_pkg::gpio_t    sync1;
periph_pkg::gpio_t    sync2;
logic                 wr_en;
periph_pkg::reg_idx_t idx;

assign idx   = apbs_req.paddr[periph_pkg::W_REG_IDX+1:2];
assign wr_en = apbs_req.psel && apbs_req.penable && apbs_req.pwrite;

always_ff @(posedge clk) begin
	if (reset) begin
		out_r <= '0;
		oe_r  <= '0;
		fsel  <= 1'b0;
	end else if (wr_en) begin
		case (idx)
			periph_pkg::GPIO_OUT:  out_r <= apbs_req.pwdata[periph_pkg::N_GPIO-1:0];
			periph_pkg::GPIO_OE:   oe_r  <= apbs_req.pwdata[periph_pkg::N_GPIO-1:0];
			periph_pkg::GPIO_FSEL: fsel  <= apbs_req.pwdata[0];
			default: ;
		endcase
	end
end

// Two-flop synchronizer for the pad inputs
always_ff @(posedge clk) begin
	sync1 <= gpio_in;
	sync2 <= sync1;
end

// Pad 0 function select, PWM drives the pad with enable forced on
assign gpio_out = {out_r[periph_pkg::N_GPIO-1:1], fsel ? pwm : out_r[0]};
assign gpio_oe  = {oe_r[periph_pkg::N_GPIO-1:1], fsel | oe_r[0]};

always_comb begin
	apbs_resp.pready  = 1'b1;
	apbs_resp.pslverr = 1'b0;
	case (idx)
		periph_pkg::GPIO_OUT:  apbs_resp.prdata = periph_pkg::data_t'(out_r);
		periph_pkg::GPIO_OE:   apbs_resp.prdata = periph_pkg::data_t'(oe_r);
		periph_pkg::GPIO_IN:   apbs_resp.prdata = periph_pkg::data_t'(sync2);
		periph_pkg::GPIO_FSEL: apbs_resp.prdata = periph_pkg::data_t'(fsel);
		default:               apbs_resp.prdata = '0;
	endcase
end

endmodule

// File: design/periph_core.sv
// Peripheral subsystem top; the AHB master feeds ahb_resp.hready_resp back as ahb_req.hready
module periph_core (
	input  logic                  clk,
	input  logic                  reset,
	input  periph_pkg::ahb_req_t  ahb_req,
	input  periph_pkg::data_t     hwdata,
	output periph_pkg::ahb_resp_t ahb_resp,
	input  periph_pkg::gpio_t     gpio_in,
	output periph_pkg::gpio_t     gpio_out,
	output periph_pkg::gpio_t     gpio_oe
);

periph_pkg::ahb_req_t  sram_req;
periph_pkg::ahb_resp_t sram_resp;
periph_pkg::ahb_req_t  bridge_req;
periph_pkg::ahb_resp_t bridge_resp;
periph_pkg::apb_req_t  apb_req;
periph_pkg::apb_resp_t apb_resp;
periph_pkg::apb_req_t  pwm_req;
periph_pkg::apb_resp_t pwm_resp;
periph_pkg::apb_req_t  gpio_req;
periph_pkg::apb_resp_t gpio_resp;
logic                  pwm_level;

// ====================
// AHB side
// ====================
ahbl_decoder inst_ahbl_decoder (
	.clk         (clk),
	.reset       (reset),
	.src_req     (ahb_req),
	.src_resp    (ahb_resp),
	.sram_req    (sram_req),
	.sram_resp   (sram_resp),
	.bridge_req  (bridge_req),
	.bridge_resp (bridge_resp)
);

ahb_sync_sram inst_sram (.clk(clk), .reset(reset), .ahbls_req(sram_req),
	.ahbls_hwdata(hwdata), .ahbls_resp(sram_resp));

ahbl_to_apb inst_ahbl_to_apb (.clk(clk), .reset(reset), .ahbls_req(bridge_req),
	.ahbls_hwdata(hwdata), .ahbls_resp(bridge_resp), .apbm_req(apb_req), .apbm_resp(apb_resp));

// ====================
// APB side
// ====================
apb_splitter inst_apb_splitter (.apbs_req(apb_req), .apbs_resp(apb_resp),
	.pwm_req(pwm_req), .pwm_resp(pwm_resp), .gpio_req(gpio_req), .gpio_resp(gpio_resp));

pwm_tiny inst_pwm_tiny (.clk(clk), .reset(reset), .apbs_req(pwm_req),
	.apbs_resp(pwm_resp), .pwm(pwm_level));

gpio inst_gpio (.clk(clk), .reset(reset), .apbs_req(gpio_req), .apbs_resp(gpio_resp),
	.pwm(pwm_level), .gpio_in(gpio_in), .gpio_out(gpio_out), .gpio_oe(gpio_oe));

endmodule

// File: design/periph_pkg.sv
// Shared widths, address map and AHB/APB types; peripheral registers are 32-bit word offsets
package periph_pkg;

// ====================
// Widths and sizes
// ====================
localparam int W_ADDR     = 32;
localparam int W_DATA     = 32;
localparam int W_PADDR    = 16;
localparam int N_GPIO     = 16;
localparam int N_LANES    = W_DATA / 8;
localparam int SRAM_DEPTH = 2048;
localparam int W_SRAM_IDX = $clog2(SRAM_DEPTH);
// Word index inside one 4 KiB peripheral block
localparam int W_REG_IDX  = 10;

typedef logic [W_ADDR-1:0]     addr_t;
typedef logic [W_PADDR-1:0]    paddr_t;
typedef logic [W_DATA-1:0]     data_t;
typedef logic [N_GPIO-1:0]     gpio_t;
typedef logic [W_SRAM_IDX-1:0] sram_idx_t;
typedef logic [W_REG_IDX-1:0]  reg_idx_t;
typedef logic [2:0]            hsize_t;

localparam hsize_t HSIZE_BYTE = 3'd0;
localparam hsize_t HSIZE_HALF = 3'd1;
localparam hsize_t HSIZE_WORD = 3'd2;

// ====================
// Address map
// ====================
localparam addr_t  SRAM_BASE   = 32'h2000_0000;
localparam addr_t  APB_BASE    = 32'h4000_0000;
localparam addr_t  REGION_MASK = 32'he000_0000;
localparam paddr_t PWM_BASE    = 16'h0000;
localparam paddr_t GPIO_BASE   = 16'h1000;
localparam paddr_t PERIPH_MASK = 16'hf000;

// Register word offsets
localparam reg_idx_t PWM_CSR   = 10'd0;
localparam reg_idx_t PWM_TOP   = 10'd1;
localparam reg_idx_t PWM_CMP   = 10'd2;
localparam reg_idx_t GPIO_OUT  = 10'd0;
localparam reg_idx_t GPIO_OE   = 10'd1;
localparam reg_idx_t GPIO_IN   = 10'd2;
localparam reg_idx_t GPIO_FSEL = 10'd3;

// Literals carry prefixes since both enums share this scope
typedef enum logic [1:0] {
	HTRANS_IDLE   = 2'b00,
	HTRANS_BUSY   = 2'b01,
	HTRANS_NONSEQ = 2'b10,
	HTRANS_SEQ    = 2'b11
} htrans_t;

typedef enum logic [1:0] {
	BR_IDLE,
	BR_SETUP,
	BR_ACCESS,
	BR_ERR2
} bridge_state_t;

// ====================
// Bus structs
// ====================
typedef struct packed {
	addr_t   haddr;
	logic    hwrite;
	htrans_t htrans;
	hsize_t  hsize;
	logic    hready;
} ahb_req_t;

typedef struct packed {
	logic  hready_resp;
	logic  hresp;
	data_t hrdata;
} ahb_resp_t;

typedef struct packed {
	paddr_t paddr;
	logic   psel;
	logic   penable;
	logic   pwrite;
	data_t  pwdata;
} apb_req_t;

typedef struct packed {
	logic  pready;
	data_t prdata;
	logic  pslverr;
} apb_resp_t;

endpackage

// File: design/pwm_tiny.sv
// APB PWM with 8-bit counter; output is high for CMP of every TOP+1 cycles, CMP > TOP stays high
module pwm_tiny (
	input  logic                  clk,
	input  logic                  reset,
	input  periph_pkg::apb_req_t  apbs_req,
	output periph_pkg::apb_resp_t apbs_resp,
	output logic                  pwm
);

logic                 en;
logic [7:0]           top;
logic [7:0]           cmp;
logic [7:0]           ctr;
logic                 wr_en;
periph_pkg::reg_idx_t idx;

assign idx   = apbs_req.paddr[periph_pkg::W_REG_IDX+1:2];
assign wr_en = apbs_req.psel && apbs_req.penable && apbs_req.pwrite;

always_ff @(posedge clk) begin
	if (reset) begin
		en  <= 1'b0;
		top <= 8'd0;
		cmp <= 8'd0;
	end else if (wr_en) begin
		case (idx)
			periph_pkg::PWM_CSR: en  <= apbs_req.pwdata[0];
			periph_pkg::PWM_TOP: top <= apbs_req.pwdata[7:0];
			periph_pkg::PWM_CMP: cmp <= apbs_req.pwdata[7:0];
			default: ;
		endcase
	end
end

// Counter wraps at TOP, pwm follows one cycle behind
always_ff @(posedge clk) begin
	if (reset || !en) begin
		ctr <= 8'd0;
		pwm <= 1'b0;
	end else begin
		ctr <= ctr == top ? 8'd0 : ctr + 8'd1;
		pwm <= ctr < cmp;
	end
end

always_comb begin
	apbs_resp.pready  = 1'b1;
	apbs_resp.pslverr = 1'b0;
	case (idx)
		periph_pkg::PWM_CSR: apbs_resp.prdata = periph_pkg::data_t'(en);
		periph_pkg::PWM_TOP: apbs_resp.prdata = periph_pkg::data_t'(top);
		periph_pkg::PWM_CMP: apbs_resp.prdata = periph_pkg::data_t'(cmp);
		default:             apbs_resp.prdata = '0;
	endcase
end

endmodule

// File: filelist.f
design/periph_pkg.sv
design/ahbl_decoder.sv
design/ahb_sync_sram.sv
design/ahbl_to_apb.sv
design/apb_splitter.sv
design/pwm_tiny.sv
design/gpio.sv
design/periph_core.sv
sim/tb_periph_core.sv

// File: sim/tb_periph_core.sv
// Single AHB master in place of the CPU; checks SRAM, GPIO, PWM on pad 0, error responses, reset state
module tb_periph_core;

localparam int CLK_PERIOD   = 8;
localparam int RESET_CYCLES = 16;
// Tests take about 250 cycles with the longest PWM period, kept with a wide margin
localparam int WATCHDOG_CYCLES = 4000;
localparam int MAX_SEQ = 16;
localparam int PWM_PERIODS = 4;

logic                  clk;
logic                  reset;
periph_pkg::addr_t     haddr;
logic                  hwrite;
periph_pkg::htrans_t   htrans;
periph_pkg::hsize_t    hsize;
periph_pkg::data_t     hwdata;
periph_pkg::ahb_req_t  ahb_req;
periph_pkg::ahb_resp_t ahb_resp;
periph_pkg::gpio_t     gpio_in;
periph_pkg::gpio_t     gpio_out;
periph_pkg::gpio_t     gpio_oe;

// Transfer list for one pipelined sequence and its results
periph_pkg::addr_t  seq_addr  [MAX_SEQ];
logic               seq_write [MAX_SEQ];
periph_pkg::hsize_t seq_size  [MAX_SEQ];
periph_pkg::data_t  seq_wdata [MAX_SEQ];
periph_pkg::data_t  seq_rdata [MAX_SEQ];
logic               seq_err   [MAX_SEQ];
logic               seq_err_wait [MAX_SEQ];
int                 seq_len;

periph_pkg::data_t sram_model [int];
int errors;
int tests_run;
int tests_failed;
int test_start_errors;

// Master hready is the returned hready_resp
assign ahb_req = '{haddr: haddr, hwrite: hwrite, htrans: htrans, hsize: hsize,
	hready: ahb_resp.hready_resp};

periph_core i_dut (
	.clk      (clk),
	.reset    (reset),
	.ahb_req  (ahb_req),
	.hwdata   (hwdata),
	.ahb_resp (ahb_resp),
	.gpio_in  (gpio_in),
	.gpio_out (gpio_out),
	.gpio_oe  (gpio_oe)
);

initial begin
	clk = 1'b0;
	forever #(CLK_PERIOD / 2) clk = ~clk;
end

initial begin
	repeat (WATCHDOG_CYCLES) @(posedge clk);
	$display("watchdog expired after %0d cycles, a test is stuck", WATCHDOG_CYCLES);
	$display("sim failed");
	$finish;
end

// ====================
// Bus protocol checks
// ====================
a_err_second: assert property (@(posedge clk) disable iff (reset)
	ahb_resp.hresp && !ahb_resp.hready_resp |=> ahb_resp.hresp && ahb_resp.hready_resp)
	else begin
		errors++;
		$display("error response did not finish with hresp and hready_resp both high");
	end

a_err_first: assert property (@(posedge clk) disable iff (reset)
	ahb_resp.hresp && ahb_resp.hready_resp |-> $past(ahb_resp.hresp) && !$past(ahb_resp.hready_resp))
	else begin
		errors++;
		$display("error response ended without a first cycle holding hready_resp low");
	end

a_reset_state: assert property (@(posedge clk)
	$fell(reset) |-> ahb_resp.hready_resp && !ahb_resp.hresp && gpio_oe == '0 && gpio_out == '0)
	else begin
		errors++;
		$display("bus or pads not idle when reset was released");
	end

// ====================
// Helpers
// ====================
function automatic void check_value(string name, periph_pkg::data_t expected,
	periph_pkg::data_t actual);
	a_value: assert (actual == expected)
		else begin
			errors++;
			$display("FAIL %s expected %h actual %h", name, expected, actual);
		end
endfunction

function automatic periph_pkg::addr_t sram_addr(int idx);
	return periph_pkg::SRAM_BASE | (periph_pkg::addr_t'(idx) << 2);
endfunction

function automatic periph_pkg::addr_t apb_addr(periph_pkg::paddr_t block,
	periph_pkg::reg_idx_t r);
	return periph_pkg::APB_BASE | periph_pkg::addr_t'(block) | (periph_pkg::addr_t'(r) << 2);
endfunction

// Little-endian: byte at address offset n sits in bits 8n+7..8n
function automatic periph_pkg::data_t merge_lanes(periph_pkg::data_t old_word,
	periph_pkg::data_t wdata, logic [1:0] offset, periph_pkg::hsize_t size);
	periph_pkg::data_t result;
	int                nbytes;
	result = old_word;
	nbytes = 1 << size;
	for (int b = 0; b < nbytes; b++)
		result[8*(offset+b) +: 8] = wdata[8*(offset+b) +: 8];
	return result;
endfunction

task automatic start_seq();
	seq_len = 0;
endtask

task automatic add_xfer(periph_pkg::addr_t addr, logic write, periph_pkg::hsize_t size,
	periph_pkg::data_t wdata);
	seq_addr[seq_len]  = addr;
	seq_write[seq_len] = write;
	seq_size[seq_len]  = size;
	seq_wdata[seq_len] = wdata;
	seq_len++;
endtask

// Address phase of transfer i overlaps the data phase of transfer i-1
task automatic run_seq();
	logic              rdy;
	logic              err;
	logic              waited_err;
	periph_pkg::data_t rdata;
	for (int i = 0; i <= seq_len; i++) begin
		if (i < seq_len) begin
			haddr  = seq_addr[i];
			hwrite = seq_write[i];
			hsize  = seq_size[i];
			htrans = periph_pkg::HTRANS_NONSEQ;
		end else begin
			htrans = periph_pkg::HTRANS_IDLE;
		end
		if (i > 0)
			hwdata = seq_wdata[i-1];
		waited_err = 1'b0;
		do begin
			@(negedge clk);
			rdy   = ahb_resp.hready_resp;
			err   = ahb_resp.hresp;
			rdata = ahb_resp.hrdata;
			if (!rdy && err)
				waited_err = 1'b1;
			@(posedge clk);
		end while (!rdy);
		#1;
		if (i > 0) begin
			seq_rdata[i-1]    = rdata;
			seq_err[i-1]      = err;
			seq_err_wait[i-1] = waited_err;
		end
	end
endtask

task automatic report_test(string name);
	tests_run++;
	if (errors == test_start_errors) begin
		$display("test %s: ok", name);
	end else begin
		tests_failed++;
		$display("test %s: %0d check(s) failed", name, errors - test_start_errors);
	end
	test_start_errors = errors;
endtask

// ====================
// Tests
// ====================
task automatic test_reset_state();
	@(negedge clk);
	check_value("reset hready_resp", 32'd1, periph_pkg::data_t'(ahb_resp.hready_resp));
	check_value("reset hresp", 32'd0, periph_pkg::data_t'(ahb_resp.hresp));
	check_value("reset gpio_oe", 32'd0, periph_pkg::data_t'(gpio_oe));
	check_value("reset gpio_out", 32'd0, periph_pkg::data_t'(gpio_out));
	check_value("reset pad 0", 32'd0, periph_pkg::data_t'(gpio_out[0]));
	@(posedge clk);
	#1;
endtask

task automatic test_sram_words();
	int                idxs [8];
	int                idx;
	periph_pkg::data_t wd;
	start_seq();
	for (int i = 0; i < 8; i++) begin
		idxs[i] = int'($urandom % periph_pkg::SRAM_DEPTH);
		wd = $urandom;
		sram_model[idxs[i]] = wd;
		add_xfer(sram_addr(idxs[i]), 1'b1, periph_pkg::HSIZE_WORD, wd);
	end
	run_seq();
	start_seq();
	for (int i = 0; i < 8; i++)
		add_xfer(sram_addr(idxs[i]), 1'b0, periph_pkg::HSIZE_WORD, '0);
	run_seq();
	for (int i = 0; i < 8; i++)
		check_value($sformatf("sram_words read %0d", i), sram_model[idxs[i]], seq_rdata[i]);
	// Read straight after a write to the same word
	idx = int'($urandom % periph_pkg::SRAM_DEPTH);
	wd = $urandom;
	sram_model[idx] = wd;
	start_seq();
	add_xfer(sram_addr(idx), 1'b1, periph_pkg::HSIZE_WORD, wd);
	add_xfer(sram_addr(idx), 1'b0, periph_pkg::HSIZE_WORD, '0);
	run_seq();
	check_value("sram_words write then read", wd, seq_rdata[1]);
endtask

task automatic test_sram_lanes();
	int                 idx;
	periph_pkg::data_t  base_word;
	periph_pkg::data_t  lane_data;
	periph_pkg::data_t  expected;
	logic [1:0]         offset;
	periph_pkg::hsize_t size;
	for (int k = 0; k < 6; k++) begin
		idx = int'($urandom % periph_pkg::SRAM_DEPTH);
		base_word = $urandom;
		lane_data = $urandom;
		if (k < 4) begin
			size   = periph_pkg::HSIZE_BYTE;
			offset = 2'(k);
		end else begin
			size   = periph_pkg::HSIZE_HALF;
			offset = 2'((k - 4) * 2);
		end
		expected = merge_lanes(base_word, lane_data, offset, size);
		sram_model[idx] = expected;
		start_seq();
		add_xfer(sram_addr(idx), 1'b1, periph_pkg::HSIZE_WORD, base_word);
		add_xfer(sram_addr(idx) | periph_pkg::addr_t'(offset), 1'b1, size, lane_data);
		add_xfer(sram_addr(idx), 1'b0, periph_pkg::HSIZE_WORD, '0);
		run_seq();
		check_value($sformatf("sram_lanes size %0d offset %0d", size, offset), expected,
			seq_rdata[2]);
	end
endtask

task automatic test_gpio();
	periph_pkg::gpio_t out_val;
	periph_pkg::gpio_t oe_val;
	periph_pkg::gpio_t pads_out;
	periph_pkg::gpio_t pads_oe;
	out_val = periph_pkg::gpio_t'($urandom);
	oe_val  = periph_pkg::gpio_t'($urandom);
	start_seq();
	add_xfer(apb_addr(periph_pkg::GPIO_BASE, periph_pkg::GPIO_OUT), 1'b1,
		periph_pkg::HSIZE_WORD, periph_pkg::data_t'(out_val));
	add_xfer(apb_addr(periph_pkg::GPIO_BASE, periph_pkg::GPIO_OE), 1'b1,
		periph_pkg::HSIZE_WORD, periph_pkg::data_t'(oe_val));
	add_xfer(apb_addr(periph_pkg::GPIO_BASE, periph_pkg::GPIO_OUT), 1'b0,
		periph_pkg::HSIZE_WORD, '0);
	add_xfer(apb_addr(periph_pkg::GPIO_BASE, periph_pkg::GPIO_OE), 1'b0,
		periph_pkg::HSIZE_WORD, '0);
	run_seq();
	check_value("gpio OUT readback", periph_pkg::data_t'(out_val), seq_rdata[2]);
	check_value("gpio OE readback", periph_pkg::data_t'(oe_val), seq_rdata[3]);
	@(negedge clk);
	pads_out = gpio_out;
	pads_oe  = gpio_oe;
	@(posedge clk);
	#1;
	check_value("gpio_out pads", periph_pkg::data_t'(out_val), periph_pkg::data_t'(pads_out));
	check_value("gpio_oe pads", periph_pkg::data_t'(oe_val), periph_pkg::data_t'(pads_oe));
	gpio_in = periph_pkg::gpio_t'($urandom);
	repeat (2) @(posedge clk);
	#1;
	start_seq();
	add_xfer(apb_addr(periph_pkg::GPIO_BASE, periph_pkg::GPIO_IN), 1'b0,
		periph_pkg::HSIZE_WORD, '0);
	run_seq();
	check_value("gpio IN readback", periph_pkg::data_t'(gpio_in), seq_rdata[0]);
endtask

task automatic test_pwm();
	int   top;
	int   cmp;
	int   highs;
	int   count;
	int   period;
	logic level;
	logic prev;
	logic rose;
	top = 3 + int'($urandom % 7);
	cmp = 1 + int'($urandom % top);
	start_seq();
	add_xfer(apb_addr(periph_pkg::GPIO_BASE, periph_pkg::GPIO_FSEL), 1'b1,
		periph_pkg::HSIZE_WORD, 32'd1);
	// OE cleared so the pad 0 enable comes from the function select alone
	add_xfer(apb_addr(periph_pkg::GPIO_BASE, periph_pkg::GPIO_OE), 1'b1,
		periph_pkg::HSIZE_WORD, '0);
	add_xfer(apb_addr(periph_pkg::PWM_BASE, periph_pkg::PWM_TOP), 1'b1,
		periph_pkg::HSIZE_WORD, periph_pkg::data_t'(top));
	add_xfer(apb_addr(periph_pkg::PWM_BASE, periph_pkg::PWM_CMP), 1'b1,
		periph_pkg::HSIZE_WORD, periph_pkg::data_t'(cmp));
	add_xfer(apb_addr(periph_pkg::PWM_BASE, periph_pkg::PWM_CSR), 1'b1,
		periph_pkg::HSIZE_WORD, 32'd1);
	add_xfer(apb_addr(periph_pkg::PWM_BASE, periph_pkg::PWM_TOP), 1'b0,
		periph_pkg::HSIZE_WORD, '0);
	add_xfer(apb_addr(periph_pkg::PWM_BASE, periph_pkg::PWM_CMP), 1'b0,
		periph_pkg::HSIZE_WORD, '0);
	run_seq();
	check_value("pwm TOP readback", periph_pkg::data_t'(top), seq_rdata[5]);
	check_value("pwm CMP readback", periph_pkg::data_t'(cmp), seq_rdata[6]);
	// Align to the first high cycle of a period
	prev = 1'b1;
	rose = 1'b0;
	for (int c = 0; c < 64 && !rose; c++) begin
		@(negedge clk);
		level = gpio_out[0];
		rose  = level && !prev;
		prev  = level;
	end
	if (!rose) begin
		errors++;
		$display("pad 0 never went high with the PWM routed to it");
	end else begin
		check_value("pwm pad 0 enable", 32'd1, periph_pkg::data_t'(gpio_oe[0]));
		highs  = 1;
		count  = 1;
		period = 0;
		while (period < PWM_PERIODS) begin
			if (count == top + 1) begin
				check_value($sformatf("pwm period %0d high cycles", period), cmp, highs);
				highs = 0;
				count = 0;
				period++;
			end else begin
				@(negedge clk);
				if (gpio_out[0])
					highs++;
				count++;
			end
		end
	end
	@(posedge clk);
	#1;
endtask

task automatic test_errors();
	int                idx;
	periph_pkg::data_t wd;
	idx = int'($urandom % periph_pkg::SRAM_DEPTH);
	wd  = $urandom;
	sram_model[idx] = wd;
	start_seq();
	add_xfer(sram_addr(idx), 1'b1, periph_pkg::HSIZE_WORD, wd);
	add_xfer(32'h6000_0000, 1'b0, periph_pkg::HSIZE_WORD, '0);
	add_xfer(periph_pkg::APB_BASE | 32'h2000, 1'b1, periph_pkg::HSIZE_WORD, $urandom);
	add_xfer(sram_addr(idx), 1'b0, periph_pkg::HSIZE_WORD, '0);
	run_seq();
	check_value("unmapped AHB hresp", 32'd1, periph_pkg::data_t'(seq_err[1]));
	check_value("unmapped AHB wait cycle", 32'd1, periph_pkg::data_t'(seq_err_wait[1]));
	check_value("unmapped APB hresp", 32'd1, periph_pkg::data_t'(seq_err[2]));
	check_value("unmapped APB wait cycle", 32'd1, periph_pkg::data_t'(seq_err_wait[2]));
	check_value("read after errors hresp", 32'd0, periph_pkg::data_t'(seq_err[3]));
	check_value("read after errors data", wd, seq_rdata[3]);
endtask

// ====================
// Main sequence
// ====================
initial begin
	void'($urandom(32'h5610494c));
	errors            = 0;
	tests_run         = 0;
	tests_failed      = 0;
	test_start_errors = 0;
	seq_len           = 0;
	reset  = 1'b1;
	haddr  = '0;
	hwrite = 1'b0;
	htrans = periph_pkg::HTRANS_IDLE;
	hsize  = periph_pkg::HSIZE_WORD;
	hwdata = '0;
	gpio_in = '0;
	repeat (RESET_CYCLES) @(posedge clk);
	#1;
	reset = 1'b0;

	test_reset_state();
	report_test("reset_state");
	test_sram_words();
	report_test("sram_words");
	test_sram_lanes();
	report_test("sram_lanes");
	test_gpio();
	report_test("gpio");
	test_pwm();
	report_test("pwm");
	test_errors();
	report_test("errors");

	$display("tests run %0d, tests failed %0d, checks failed %0d", tests_run, tests_failed,
		errors);
	if (errors == 0)
		$display("sim passed");
	else
		$display("sim failed");
	$finish;
end

endmodule
